//--- all.f
verilog/mxint_linear_pkg.sv
verilog/mxint_circular.sv
verilog/mxint_dot_product.sv
verilog/mxint_accumulator.sv
verilog/mxint_cast.sv
verilog/mxint_linear.sv
test/mxint_linear_checker.sv
test/mxint_linear_tb.sv

//--- test/mxint_linear_checker.sv
//################################################
// Concurrent checks bound into mxint_linear. Needs
// the weight buffer to be named weight_buffer.
// Each failure raises $error and bumps fail_count,
// which the testbench watches during the run.
//################################################
`timescale 1ns/1ns

module mxint_linear_checker
  import mxint_linear_pkg::*;
#(
  parameter int OUT_MAN_WIDTH = 8,
  parameter int OUT_EXP_WIDTH = 6,
  parameter int BLOCK         = 4
) (
  input logic                     clk,
  input logic                     rst,
  input logic [OUT_MAN_WIDTH-1:0] mdata_out [BLOCK-1:0],
  input logic [OUT_EXP_WIDTH-1:0] edata_out,
  input logic                     data_out_valid,
  input logic                     data_out_ready,
  input logic                     data_in_ready,
  input logic                     weight_ready,
  input logic                     bias_ready,
  input circ_state_t              weight_state
);

  int                             fail_count = 0;
  logic [OUT_MAN_WIDTH*BLOCK-1:0] out_bits;

  always_comb begin
    for (int i = 0; i < BLOCK; i++) begin
      out_bits[i*OUT_MAN_WIDTH +: OUT_MAN_WIDTH] = mdata_out[i];
    end
  end

  // A stalled output keeps its block until it is taken
  assert property (@(posedge clk) disable iff (rst)
    data_out_valid && !data_out_ready |=>
      data_out_valid && $stable(out_bits) && $stable(edata_out))
    else begin
      $error("output block changed while stalled");
      fail_count++;
    end

  // Nothing is offered or accepted in the cycle after a reset edge
  assert property (@(posedge clk)
    rst |=> !data_out_valid && !data_in_ready && !weight_ready && !bias_ready)
    else begin
      $error("valid or ready high right after reset");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst)
    weight_state == circ_replay |-> !weight_ready)
    else begin
      $error("weight ready high during replay");
      fail_count++;
    end

endmodule

bind mxint_linear mxint_linear_checker #(
  .OUT_MAN_WIDTH(OUT_MAN_WIDTH),
  .OUT_EXP_WIDTH(OUT_EXP_WIDTH),
  .BLOCK        (PAR * PAR)
) linear_checks (
  .clk           (clk),
  .rst           (rst),
  .mdata_out     (mdata_out_0),
  .edata_out     (edata_out_0),
  .data_out_valid(data_out_0_valid),
  .data_out_ready(data_out_0_ready),
  .data_in_ready (data_in_0_ready),
  .weight_ready  (weight_ready),
  .bias_ready    (bias_ready),
  .weight_state  (weight_buffer.state)
);

//--- test/mxint_linear_tb.sv
//################################################
// Testbench for mxint_linear at its default sizes
// (4x4 matrices, PAR 2). Runs from the project root
// so the data file path resolves. Inputs change
// 2 ns after a rising edge; ready and valid are
// sampled on the falling edge.
//################################################
`timescale 1ns/1ns

module mxint_linear_tb;

  localparam int PAR            = 2;
  localparam int BLOCK          = PAR * PAR;
  localparam int RUNS           = 2;
  localparam int DATA_PER_RUN   = 4;
  localparam int WEIGHT_OFS     = 4;
  localparam int WEIGHT_PER_RUN = 4;
  localparam int BIAS_OFS       = 8;
  localparam int BIAS_PER_RUN   = 2;
  localparam int OUT_OFS        = 10;
  localparam int OUT_PER_RUN    = 4;
  localparam int REC_PER_RUN    = 14;
  localparam int TOTAL_OUT      = RUNS * OUT_PER_RUN;
  localparam int RESET_CYCLES   = 4;
  localparam int TIMEOUT_CYCLES = 300 * TOTAL_OUT + 100;

  logic       clk;
  logic       rst;
  logic [7:0] mdata_in_0 [BLOCK-1:0];
  logic [3:0] edata_in_0;
  logic       data_in_0_valid;
  logic       data_in_0_ready;
  logic [7:0] mweight [BLOCK-1:0];
  logic [3:0] eweight;
  logic       weight_valid;
  logic       weight_ready;
  logic [7:0] mbias [PAR-1:0];
  logic [3:0] ebias;
  logic       bias_valid;
  logic       bias_ready;
  logic [7:0] mdata_out_0 [BLOCK-1:0];
  logic [5:0] edata_out_0;
  logic       data_out_0_valid;
  logic       data_out_0_ready;

  // Each record is the exponent byte followed by mantissa bytes 0..3
  logic [39:0] records [0:RUNS*REC_PER_RUN-1];
  integer      seed = 32'hd551;
  int          cycles = 0;

  mxint_linear dut (
    .clk, .rst,
    .mdata_in_0, .edata_in_0, .data_in_0_valid, .data_in_0_ready,
    .mweight, .eweight, .weight_valid, .weight_ready,
    .mbias, .ebias, .bias_valid, .bias_ready,
    .mdata_out_0, .edata_out_0, .data_out_0_valid, .data_out_0_ready
  );

  always #20 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAIL %s expected %0h actual %0h", name, expected, actual);
    $display("TESTBENCH FAILED");
    $fatal(1, "output mismatch");
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "run aborted");
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    assert (cycles <= TIMEOUT_CYCLES)
      else abort_run($sformatf("Timeout after %0d cycles, outputs missing", cycles));
  end

  always @(dut.linear_checks.fail_count) begin
    assert (dut.linear_checks.fail_count == 0)
      else abort_run("A bound handshake check failed");
  end

  task automatic check_quiet(input string when);
    assert (!data_out_0_valid && !data_in_0_ready && !weight_ready && !bias_ready)
      else abort_run($sformatf("Output valid or an input ready was high %s", when));
  endtask

  // Zero to three idle cycles on the drive phase
  task automatic idle_cycles();
    int gap;
    gap = $random(seed) & 3;
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic drive_data();
    logic [39:0] rec;
    logic        took;
    for (int r = 0; r < RUNS; r++) begin
      for (int b = 0; b < DATA_PER_RUN; b++) begin
        rec = records[r*REC_PER_RUN + b];
        data_in_0_valid = 1'b0;
        idle_cycles();
        for (int m = 0; m < BLOCK; m++) begin
          mdata_in_0[m] = rec[31-8*m -: 8];
        end
        edata_in_0      = rec[35:32];
        data_in_0_valid = 1'b1;
        took = 1'b0;
        while (!took) begin
          @(negedge clk);
          took = data_in_0_ready;
          @(posedge clk);
          #2;
        end
      end
    end
    data_in_0_valid = 1'b0;
  endtask

  task automatic stream_weights();
    logic [39:0] rec;
    logic        took;
    for (int r = 0; r < RUNS; r++) begin
      for (int b = 0; b < WEIGHT_PER_RUN; b++) begin
        rec = records[r*REC_PER_RUN + WEIGHT_OFS + b];
        weight_valid = 1'b0;
        idle_cycles();
        for (int m = 0; m < BLOCK; m++) begin
          mweight[m] = rec[31-8*m -: 8];
        end
        eweight      = rec[35:32];
        weight_valid = 1'b1;
        took = 1'b0;
        while (!took) begin
          @(negedge clk);
          took = weight_ready;
          @(posedge clk);
          #2;
        end
      end
    end
    weight_valid = 1'b0;
  endtask

  task automatic send_bias();
    logic [39:0] rec;
    logic        took;
    for (int r = 0; r < RUNS; r++) begin
      for (int b = 0; b < BIAS_PER_RUN; b++) begin
        rec = records[r*REC_PER_RUN + BIAS_OFS + b];
        bias_valid = 1'b0;
        idle_cycles();
        for (int m = 0; m < PAR; m++) begin
          mbias[m] = rec[31-8*m -: 8];
        end
        ebias      = rec[35:32];
        bias_valid = 1'b1;
        took = 1'b0;
        while (!took) begin
          @(negedge clk);
          took = bias_ready;
          @(posedge clk);
          #2;
        end
      end
    end
    bias_valid = 1'b0;
  endtask

  // Random back-pressure with each taken block compared in order
  task automatic collect_outputs();
    logic [39:0] rec;
    logic        taken;
    for (int n = 0; n < TOTAL_OUT; n++) begin
      rec   = records[(n / OUT_PER_RUN) * REC_PER_RUN + OUT_OFS + n % OUT_PER_RUN];
      taken = 1'b0;
      while (!taken) begin
        @(posedge clk);
        #2;
        data_out_0_ready = ($random(seed) & 3) != 0;
        @(negedge clk);
        taken = data_out_0_valid && data_out_0_ready;
      end
      for (int m = 0; m < BLOCK; m++) begin
        assert (mdata_out_0[m] == rec[31-8*m -: 8])
          else report_mismatch($sformatf("mdata_out_0[%0d]", m), rec[31-8*m -: 8],
                               mdata_out_0[m]);
      end
      assert (edata_out_0 == rec[37:32])
        else report_mismatch("edata_out_0", rec[37:32], edata_out_0);
    end
  endtask

  initial begin
    clk              = 1'b0;
    rst              = 1'b1;
    data_in_0_valid  = 1'b0;
    weight_valid     = 1'b0;
    bias_valid       = 1'b0;
    data_out_0_ready = 1'b0;
    edata_in_0       = '0;
    eweight          = '0;
    ebias            = '0;
    for (int m = 0; m < BLOCK; m++) begin
      mdata_in_0[m] = '0;
      mweight[m]    = '0;
    end
    for (int m = 0; m < PAR; m++) begin
      mbias[m] = '0;
    end
    $readmemh("test/mxint_linear_testdata.txt", records);
    assert (!$isunknown(records[RUNS*REC_PER_RUN-1]))
      else abort_run("Test data file is missing or too short");

    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clk);
      #2;
      check_quiet("during reset");
    end
    rst = 1'b0;
    @(negedge clk);
    check_quiet("in the first cycle after reset");
    @(posedge clk);
    #2;

    fork
      drive_data();
      stream_weights();
      send_bias();
      collect_outputs();
    join

    if (dut.linear_checks.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("Bound handshake checks reported %0d failures",
               dut.linear_checks.fail_count);
      $display("TESTBENCH FAILED");
      $fatal(1, "checker failures");
    end
  end

endmodule

//--- test/mxint_linear_testdata.txt
// Each line: exponent byte, then mantissa bytes 0..3 (signed, two's complement)
// Per run: 4 data, 4 weight, 2 bias (mantissas 0..1 used), 4 expected outputs
// Run 1, all exponents zero, results fit in 8 bits
000102ff00
0003040201
0003fe0201
000100fffd
0001000201
0002ff0001
00ff0300fe
0001000102
0005fd0000
0002010000
00080507fc
000a080505
000a0108ff
00fa0602f8
// Run 2, mixed exponents, truncating alignment and cast shifts
0032e20764
0203fb0b09
01c4190df9
ff5a2ddf11
000302ff04
0005f90601
0102fd0a01
fff7040703
0107fb0000
030d060000
0325ef1955
03307db54a
03e94bf6e9
05e5bf0b0f

//--- verilog/mxint_accumulator.sv
//################################################
// Sums DEPTH product blocks over the inner dimension
// and then one bias block when HAS_BIAS is set. The
// smaller-exponent side is shifted right and
// truncated toward minus infinity. No new item is
// taken while a result waits for ready.
//################################################
`timescale 1ns/1ns

module mxint_accumulator
  import mxint_linear_pkg::*;
#(
  parameter int IN_MAN_WIDTH   = 17,
  parameter int EXP_WIDTH      = 5,
  parameter int BIAS_MAN_WIDTH = 8,
  parameter int BIAS_EXP_WIDTH = 4,
  parameter int ACC_WIDTH      = 19,
  parameter int PAR            = 2,
  parameter int DEPTH          = 2,
  parameter int HAS_BIAS       = 1
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [IN_MAN_WIDTH-1:0]   mdata_in [PAR*PAR-1:0],
  input  logic [EXP_WIDTH-1:0]      edata_in,
  input  logic                      data_in_valid,
  output logic                      data_in_ready,
  input  logic [BIAS_MAN_WIDTH-1:0] mbias [PAR-1:0],
  input  logic [BIAS_EXP_WIDTH-1:0] ebias,
  input  logic                      bias_valid,
  output logic                      bias_ready,
  output logic [ACC_WIDTH-1:0]      mdata_out [PAR*PAR-1:0],
  output logic [EXP_WIDTH-1:0]      edata_out,
  output logic                      data_out_valid,
  input  logic                      data_out_ready
);

  localparam int BLOCK       = PAR * PAR;
  localparam int DIFF_WIDTH  = EXP_WIDTH + exp_sum_extra;
  localparam int COUNT_WIDTH = DEPTH > 1 ? $clog2(DEPTH) : 1;

  acc_state_t                   state;
  logic [COUNT_WIDTH-1:0]       count;
  logic signed [ACC_WIDTH-1:0]  item [BLOCK-1:0];
  logic signed [ACC_WIDTH-1:0]  sum_next [BLOCK-1:0];
  logic signed [EXP_WIDTH-1:0]  item_exp;
  logic signed [EXP_WIDTH-1:0]  exp_next;
  logic signed [DIFF_WIDTH-1:0] diff;
  logic signed [DIFF_WIDTH-1:0] diff_mag;
  logic [DIFF_WIDTH-1:0]        shamt;
  logic                         item_larger;
  logic                         take_data;
  logic                         take_bias;
  logic                         first;

  assign data_in_ready  = (state == acc_sum);
  assign bias_ready     = (state == acc_bias);
  assign data_out_valid = (state == acc_hold);
  assign take_data      = data_in_valid && data_in_ready;
  assign take_bias      = bias_valid && bias_ready;
  assign first          = (state == acc_sum) && (count == '0);

  // Bias row j is broadcast onto column j of every output row
  always_comb begin
    for (int i = 0; i < BLOCK; i++) begin
      if (state == acc_bias) begin
        item[i] = $signed(mbias[i % PAR]);
      end else begin
        item[i] = $signed(mdata_in[i]);
      end
    end
    if (state == acc_bias) begin
      item_exp = $signed(ebias);
    end else begin
      item_exp = $signed(edata_in);
    end
  end

  always_comb begin
    diff        = item_exp - $signed(edata_out);
    item_larger = diff > 0;
    diff_mag    = item_larger ? diff : -diff;
    // Past the full width everything is sign bits anyway
    shamt       = (diff_mag > ACC_WIDTH - 1) ? DIFF_WIDTH'(ACC_WIDTH - 1) : diff_mag;
    exp_next    = item_larger ? item_exp : $signed(edata_out);
    for (int i = 0; i < BLOCK; i++) begin
      if (item_larger) begin
        sum_next[i] = ($signed(mdata_out[i]) >>> shamt) + item[i];
      end else begin
        sum_next[i] = $signed(mdata_out[i]) + (item[i] >>> shamt);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= acc_sum;
      count <= '0;
    end else begin
      case (state)
        acc_sum: begin
          if (take_data) begin
            if (count == COUNT_WIDTH'(DEPTH - 1)) begin
              count <= '0;
              if (HAS_BIAS != 0) begin
                state <= acc_bias;
              end else begin
                state <= acc_hold;
              end
            end else begin
              count <= count + 1'b1;
            end
          end
        end
        acc_bias: if (take_bias) state <= acc_hold;
        acc_hold: if (data_out_ready) state <= acc_sum;
        default:  state <= acc_sum;
      endcase
    end
  end

  // First product of a tile loads, everything later aligns and adds
  always_ff @(posedge clk) begin
    if (take_data || take_bias) begin
      for (int i = 0; i < BLOCK; i++) begin
        mdata_out[i] <= first ? item[i] : sum_next[i];
      end
      edata_out <= first ? item_exp : exp_next;
    end
  end

endmodule

//--- verilog/mxint_cast.sv
//################################################
// Renormalises a block to OUT_MAN_WIDTH by the
// smallest shared right shift that fits every
// mantissa. Truncates, never shifts left, and
// does not saturate the exponent.
//################################################
`timescale 1ns/1ns

module mxint_cast #(
  parameter int IN_MAN_WIDTH  = 19,
  parameter int IN_EXP_WIDTH  = 5,
  parameter int OUT_MAN_WIDTH = 8,
  parameter int OUT_EXP_WIDTH = 6,
  parameter int BLOCK_SIZE    = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [IN_MAN_WIDTH-1:0]  mdata_in [BLOCK_SIZE-1:0],
  input  logic [IN_EXP_WIDTH-1:0]  edata_in,
  input  logic                     data_in_valid,
  output logic                     data_in_ready,
  output logic [OUT_MAN_WIDTH-1:0] mdata_out [BLOCK_SIZE-1:0],
  output logic [OUT_EXP_WIDTH-1:0] edata_out,
  output logic                     data_out_valid,
  input  logic                     data_out_ready
);

  localparam int MAX_SHIFT   = IN_MAN_WIDTH - OUT_MAN_WIDTH;
  localparam int SHIFT_WIDTH = MAX_SHIFT > 0 ? $clog2(MAX_SHIFT + 1) : 1;
  localparam int OUT_MAX     = 2 ** (OUT_MAN_WIDTH - 1) - 1;
  localparam int OUT_MIN     = -(2 ** (OUT_MAN_WIDTH - 1));

  logic [SHIFT_WIDTH-1:0]         shift;
  logic signed [IN_MAN_WIDTH-1:0] probe;
  logic                           fits;
  logic signed [OUT_EXP_WIDTH-1:0] exp_ext;

  assign exp_ext       = $signed(edata_in);
  assign data_in_ready = !data_out_valid || data_out_ready;

  // Scan from the largest shift down so the smallest fitting one is kept
  always_comb begin
    shift = SHIFT_WIDTH'(MAX_SHIFT);
    probe = '0;
    fits  = 1'b0;
    for (int s = MAX_SHIFT; s >= 0; s--) begin
      fits = 1'b1;
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        probe = $signed(mdata_in[i]) >>> s;
        if (probe > OUT_MAX || probe < OUT_MIN) begin
          fits = 1'b0;
        end
      end
      if (fits) begin
        shift = SHIFT_WIDTH'(s);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out_valid <= 1'b0;
    end else if (data_in_ready) begin
      data_out_valid <= data_in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (data_in_valid && data_in_ready) begin
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        mdata_out[i] <= OUT_MAN_WIDTH'($signed(mdata_in[i]) >>> shift);
      end
      edata_out <= exp_ext + OUT_EXP_WIDTH'(shift);
    end
  end

endmodule

//--- verilog/mxint_circular.sv
//################################################
// Captures BUFFER_SIZE blocks while passing them on,
// then replays them REPEAT-1 more times. Input ready
// stays low during replay and for one cycle after
// reset. REPEAT of 1 gives a plain register stage.
//################################################
`timescale 1ns/1ns

module mxint_circular
  import mxint_linear_pkg::*;
#(
  parameter int MAN_WIDTH   = 8,
  parameter int EXP_WIDTH   = 4,
  parameter int IN_NUM      = 4,
  parameter int REPEAT      = 2,
  parameter int BUFFER_SIZE = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [MAN_WIDTH-1:0] mdata_in [IN_NUM-1:0],
  input  logic [EXP_WIDTH-1:0] edata_in,
  input  logic                 data_in_valid,
  output logic                 data_in_ready,
  output logic [MAN_WIDTH-1:0] mdata_out [IN_NUM-1:0],
  output logic [EXP_WIDTH-1:0] edata_out,
  output logic                 data_out_valid,
  input  logic                 data_out_ready
);

  localparam int PTR_WIDTH  = BUFFER_SIZE > 1 ? $clog2(BUFFER_SIZE) : 1;
  localparam int PASS_WIDTH = REPEAT > 1 ? $clog2(REPEAT) : 1;

  logic [MAN_WIDTH-1:0]  mem_m [BUFFER_SIZE-1:0][IN_NUM-1:0];
  logic [EXP_WIDTH-1:0]  mem_e [BUFFER_SIZE-1:0];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [PASS_WIDTH-1:0] pass;
  circ_state_t           state;
  logic                  live;
  logic                  out_free;
  logic                  take_in;
  logic                  load_replay;

  assign out_free      = !data_out_valid || data_out_ready;
  assign data_in_ready = live && (state == circ_fill) && out_free;
  assign take_in       = data_in_valid && data_in_ready;
  assign load_replay   = (state == circ_replay) && out_free;

  always_ff @(posedge clk) begin
    if (rst) begin
      live           <= 1'b0;
      state          <= circ_fill;
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      pass           <= '0;
      data_out_valid <= 1'b0;
    end else begin
      live <= 1'b1;
      if (take_in || load_replay) begin
        data_out_valid <= 1'b1;
      end else if (data_out_ready) begin
        data_out_valid <= 1'b0;
      end
      // Last block of a fill starts the replay passes
      if (take_in) begin
        if (wr_ptr == PTR_WIDTH'(BUFFER_SIZE - 1)) begin
          wr_ptr <= '0;
          if (REPEAT > 1) begin
            state <= circ_replay;
            pass  <= PASS_WIDTH'(1);
          end
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (load_replay) begin
        if (rd_ptr == PTR_WIDTH'(BUFFER_SIZE - 1)) begin
          rd_ptr <= '0;
          if (pass == PASS_WIDTH'(REPEAT - 1)) begin
            state <= circ_fill;
            pass  <= '0;
          end else begin
            pass <= pass + 1'b1;
          end
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // New blocks go to memory and straight to the output register
  always_ff @(posedge clk) begin
    if (take_in) begin
      mem_m[wr_ptr] <= mdata_in;
      mem_e[wr_ptr] <= edata_in;
      mdata_out     <= mdata_in;
      edata_out     <= edata_in;
    end else if (load_replay) begin
      mdata_out <= mem_m[rd_ptr];
      edata_out <= mem_e[rd_ptr];
    end
  end

endmodule

//--- verilog/mxint_dot_product.sv
//################################################
// Joins one data row and one weight row of PAR
// signed mantissas. Result is registered, one cycle
// of latency, with the exponents summed exactly.
//################################################
`timescale 1ns/1ns

module mxint_dot_product
  import mxint_linear_pkg::*;
#(
  parameter int  DATA_MAN_WIDTH   = 8,
  parameter int  DATA_EXP_WIDTH   = 4,
  parameter int  WEIGHT_MAN_WIDTH = 8,
  parameter int  WEIGHT_EXP_WIDTH = 4,
  parameter int  PAR              = 2,
  localparam int PROD_MAN_WIDTH   = DATA_MAN_WIDTH + WEIGHT_MAN_WIDTH + $clog2(PAR),
  localparam int PROD_EXP_WIDTH   = (DATA_EXP_WIDTH > WEIGHT_EXP_WIDTH ?
                                     DATA_EXP_WIDTH : WEIGHT_EXP_WIDTH) + exp_sum_extra
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [DATA_MAN_WIDTH-1:0]   mdata_in [PAR-1:0],
  input  logic [DATA_EXP_WIDTH-1:0]   edata_in,
  input  logic                        data_in_valid,
  output logic                        data_in_ready,
  input  logic [WEIGHT_MAN_WIDTH-1:0] mweight [PAR-1:0],
  input  logic [WEIGHT_EXP_WIDTH-1:0] eweight,
  input  logic                        weight_valid,
  output logic                        weight_ready,
  output logic [PROD_MAN_WIDTH-1:0]   mdata_out,
  output logic [PROD_EXP_WIDTH-1:0]   edata_out,
  output logic                        data_out_valid,
  input  logic                        data_out_ready
);

  logic signed [PROD_MAN_WIDTH-1:0] dot;
  logic signed [PROD_EXP_WIDTH-1:0] exp_sum;
  logic                             out_free;
  logic                             fire;

  // Each side waits for the other before it is consumed
  assign out_free      = !data_out_valid || data_out_ready;
  assign data_in_ready = weight_valid && out_free;
  assign weight_ready  = data_in_valid && out_free;
  assign fire          = data_in_valid && weight_valid && out_free;

  always_comb begin
    dot = '0;
    for (int k = 0; k < PAR; k++) begin
      dot = dot + $signed(mdata_in[k]) * $signed(mweight[k]);
    end
    exp_sum = $signed(edata_in) + $signed(eweight);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out_valid <= 1'b0;
    end else if (out_free) begin
      data_out_valid <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      mdata_out <= dot;
      edata_out <= exp_sum;
    end
  end

endmodule

//--- verilog/mxint_linear.sv
//################################################
// Streaming MXInt linear layer, out = x * w^T + b.
// Sizes must be multiples of PAR. Data arrives by
// row-tile, weights by column-tile then inner tile,
// bias once per column-tile. Output blocks come in
// row-tile then column-tile order.
//################################################
`timescale 1ns/1ns

module mxint_linear
  import mxint_linear_pkg::*;
#(
  parameter int DATA_MAN_WIDTH   = 8,
  parameter int DATA_EXP_WIDTH   = 4,
  parameter int WEIGHT_MAN_WIDTH = 8,
  parameter int WEIGHT_EXP_WIDTH = 4,
  parameter int BIAS_MAN_WIDTH   = 8,
  parameter int BIAS_EXP_WIDTH   = 4,
  parameter int OUT_MAN_WIDTH    = 8,
  parameter int OUT_EXP_WIDTH    = 6,
  parameter int IN_SIZE          = 4,
  parameter int ROWS             = 4,
  parameter int COLS             = 4,
  parameter int PAR              = 2,
  parameter int HAS_BIAS         = 1
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [DATA_MAN_WIDTH-1:0]   mdata_in_0 [PAR*PAR-1:0],
  input  logic [DATA_EXP_WIDTH-1:0]   edata_in_0,
  input  logic                        data_in_0_valid,
  output logic                        data_in_0_ready,
  input  logic [WEIGHT_MAN_WIDTH-1:0] mweight [PAR*PAR-1:0],
  input  logic [WEIGHT_EXP_WIDTH-1:0] eweight,
  input  logic                        weight_valid,
  output logic                        weight_ready,
  input  logic [BIAS_MAN_WIDTH-1:0]   mbias [PAR-1:0],
  input  logic [BIAS_EXP_WIDTH-1:0]   ebias,
  input  logic                        bias_valid,
  output logic                        bias_ready,
  output logic [OUT_MAN_WIDTH-1:0]    mdata_out_0 [PAR*PAR-1:0],
  output logic [OUT_EXP_WIDTH-1:0]    edata_out_0,
  output logic                        data_out_0_valid,
  input  logic                        data_out_0_ready
);

  localparam int BLOCK          = PAR * PAR;
  localparam int DEPTH          = IN_SIZE / PAR;
  localparam int COL_TILES      = COLS / PAR;
  localparam int ROW_TILES      = ROWS / PAR;
  localparam int PROD_MAN_WIDTH = DATA_MAN_WIDTH + WEIGHT_MAN_WIDTH + $clog2(PAR);
  localparam int PROD_EXP_WIDTH = (DATA_EXP_WIDTH > WEIGHT_EXP_WIDTH ?
                                   DATA_EXP_WIDTH : WEIGHT_EXP_WIDTH) + exp_sum_extra;
  // Headroom for the inner sum plus the bias item
  localparam int ACC_WIDTH      = PROD_MAN_WIDTH + $clog2(DEPTH + HAS_BIAS);

  initial begin
    assert (IN_SIZE % PAR == 0) else $fatal(1, "IN_SIZE is not a multiple of PAR");
    assert (ROWS % PAR == 0 && COLS % PAR == 0)
      else $fatal(1, "ROWS and COLS must be multiples of PAR");
    assert (OUT_MAN_WIDTH < ACC_WIDTH) else $fatal(1, "OUT_MAN_WIDTH too wide");
    assert (BIAS_MAN_WIDTH <= ACC_WIDTH && BIAS_EXP_WIDTH <= PROD_EXP_WIDTH)
      else $fatal(1, "bias format wider than the accumulator");
    assert (OUT_EXP_WIDTH >= PROD_EXP_WIDTH) else $fatal(1, "OUT_EXP_WIDTH too narrow");
  end

  logic [DATA_MAN_WIDTH-1:0]   circ_mdata [BLOCK-1:0];
  logic [DATA_EXP_WIDTH-1:0]   circ_edata;
  logic                        circ_data_valid;
  logic [WEIGHT_MAN_WIDTH-1:0] circ_mweight [BLOCK-1:0];
  logic [WEIGHT_EXP_WIDTH-1:0] circ_eweight;
  logic                        circ_weight_valid;
  logic [BIAS_MAN_WIDTH-1:0]   circ_mbias [PAR-1:0];
  logic [BIAS_EXP_WIDTH-1:0]   circ_ebias;
  logic                        circ_bias_valid;
  logic                        circ_bias_ready;
  logic [PROD_MAN_WIDTH-1:0]   dp_mdata [BLOCK-1:0];
  logic [PROD_EXP_WIDTH-1:0]   dp_edata [BLOCK-1:0];
  logic [BLOCK-1:0]            dp_valid;
  logic [BLOCK-1:0]            dp_data_ready;
  logic [BLOCK-1:0]            dp_weight_ready;
  logic                        acc_in_ready;
  logic [ACC_WIDTH-1:0]        acc_mdata [BLOCK-1:0];
  logic [PROD_EXP_WIDTH-1:0]   acc_edata;
  logic                        acc_valid;
  logic                        cast_ready;

  // One data row-tile is reused for every column-tile
  mxint_circular #(
    .MAN_WIDTH  (DATA_MAN_WIDTH),
    .EXP_WIDTH  (DATA_EXP_WIDTH),
    .IN_NUM     (BLOCK),
    .REPEAT     (COL_TILES),
    .BUFFER_SIZE(DEPTH)
  ) data_buffer (
    .clk, .rst,
    .mdata_in(mdata_in_0), .edata_in(edata_in_0),
    .data_in_valid(data_in_0_valid), .data_in_ready(data_in_0_ready),
    .mdata_out(circ_mdata), .edata_out(circ_edata),
    .data_out_valid(circ_data_valid), .data_out_ready(dp_data_ready[0])
  );

  // The whole weight set is reused for every row-tile
  mxint_circular #(
    .MAN_WIDTH  (WEIGHT_MAN_WIDTH),
    .EXP_WIDTH  (WEIGHT_EXP_WIDTH),
    .IN_NUM     (BLOCK),
    .REPEAT     (ROW_TILES),
    .BUFFER_SIZE(DEPTH * COL_TILES)
  ) weight_buffer (
    .clk, .rst,
    .mdata_in(mweight), .edata_in(eweight),
    .data_in_valid(weight_valid), .data_in_ready(weight_ready),
    .mdata_out(circ_mweight), .edata_out(circ_eweight),
    .data_out_valid(circ_weight_valid), .data_out_ready(dp_weight_ready[0])
  );

  mxint_circular #(
    .MAN_WIDTH  (BIAS_MAN_WIDTH),
    .EXP_WIDTH  (BIAS_EXP_WIDTH),
    .IN_NUM     (PAR),
    .REPEAT     (ROW_TILES),
    .BUFFER_SIZE(COL_TILES)
  ) bias_buffer (
    .clk, .rst,
    .mdata_in(mbias), .edata_in(ebias),
    .data_in_valid(bias_valid), .data_in_ready(bias_ready),
    .mdata_out(circ_mbias), .edata_out(circ_ebias),
    .data_out_valid(circ_bias_valid), .data_out_ready(circ_bias_ready)
  );

  // Output element (i, j) is data row i against weight column j
  for (genvar i = 0; i < PAR; i++) begin : g_row
    for (genvar j = 0; j < PAR; j++) begin : g_col
      logic [DATA_MAN_WIDTH-1:0]   row_m [PAR-1:0];
      logic [WEIGHT_MAN_WIDTH-1:0] col_m [PAR-1:0];

      for (genvar k = 0; k < PAR; k++) begin : g_k
        assign row_m[k] = circ_mdata[i*PAR+k];
        assign col_m[k] = circ_mweight[j*PAR+k];
      end

      mxint_dot_product #(
        .DATA_MAN_WIDTH  (DATA_MAN_WIDTH),
        .DATA_EXP_WIDTH  (DATA_EXP_WIDTH),
        .WEIGHT_MAN_WIDTH(WEIGHT_MAN_WIDTH),
        .WEIGHT_EXP_WIDTH(WEIGHT_EXP_WIDTH),
        .PAR             (PAR)
      ) dp_inst (
        .clk, .rst,
        .mdata_in(row_m), .edata_in(circ_edata),
        .data_in_valid(circ_data_valid), .data_in_ready(dp_data_ready[i*PAR+j]),
        .mweight(col_m), .eweight(circ_eweight),
        .weight_valid(circ_weight_valid), .weight_ready(dp_weight_ready[i*PAR+j]),
        .mdata_out(dp_mdata[i*PAR+j]), .edata_out(dp_edata[i*PAR+j]),
        .data_out_valid(dp_valid[i*PAR+j]), .data_out_ready(acc_in_ready)
      );
    end
  end

  // All dot products run in lockstep, so instance 0 speaks for the array
  mxint_accumulator #(
    .IN_MAN_WIDTH  (PROD_MAN_WIDTH),
    .EXP_WIDTH     (PROD_EXP_WIDTH),
    .BIAS_MAN_WIDTH(BIAS_MAN_WIDTH),
    .BIAS_EXP_WIDTH(BIAS_EXP_WIDTH),
    .ACC_WIDTH     (ACC_WIDTH),
    .PAR           (PAR),
    .DEPTH         (DEPTH),
    .HAS_BIAS      (HAS_BIAS)
  ) acc_inst (
    .clk, .rst,
    .mdata_in(dp_mdata), .edata_in(dp_edata[0]),
    .data_in_valid(dp_valid[0]), .data_in_ready(acc_in_ready),
    .mbias(circ_mbias), .ebias(circ_ebias),
    .bias_valid(circ_bias_valid), .bias_ready(circ_bias_ready),
    .mdata_out(acc_mdata), .edata_out(acc_edata),
    .data_out_valid(acc_valid), .data_out_ready(cast_ready)
  );

  mxint_cast #(
    .IN_MAN_WIDTH (ACC_WIDTH),
    .IN_EXP_WIDTH (PROD_EXP_WIDTH),
    .OUT_MAN_WIDTH(OUT_MAN_WIDTH),
    .OUT_EXP_WIDTH(OUT_EXP_WIDTH),
    .BLOCK_SIZE   (BLOCK)
  ) cast_inst (
    .clk, .rst,
    .mdata_in(acc_mdata), .edata_in(acc_edata),
    .data_in_valid(acc_valid), .data_in_ready(cast_ready),
    .mdata_out(mdata_out_0), .edata_out(edata_out_0),
    .data_out_valid(data_out_0_valid), .data_out_ready(data_out_0_ready)
  );

endmodule

//--- verilog/mxint_linear_pkg.sv
//################################################
// Shared state encodings and width constants for
// the MXInt linear layer. Exponents are plain two's
// complement values with no offset.
//################################################
package mxint_linear_pkg;

  // Circular buffer: taking new blocks, or re-emitting stored ones
  typedef enum logic {
    circ_fill,
    circ_replay
  } circ_state_t;

  // Accumulator: summing products, adding bias, holding the result
  typedef enum logic [1:0] {
    acc_sum,
    acc_bias,
    acc_hold
  } acc_state_t;

  // A sum or difference of two signed exponents needs one more bit
  localparam int exp_sum_extra = 1;

endpackage
